// ==== verilog/ex_pkg.sv ====
package ex_pkg;

	// ****************************************
	// ALU operation, one-hot
	// ****************************************
	localparam int ALU_OP_W = 12;

	localparam int ALU_ADD  = 0;
	localparam int ALU_SUB  = 1;
	localparam int ALU_SLT  = 2;
	localparam int ALU_SLTU = 3;
	localparam int ALU_AND  = 4;
	localparam int ALU_NOR  = 5;
	localparam int ALU_OR   = 6;
	localparam int ALU_XOR  = 7;
	localparam int ALU_SLL  = 8;
	localparam int ALU_SRL  = 9;
	localparam int ALU_SRA  = 10;
	localparam int ALU_LUI  = 11;

	// ****************************************
	// Memory access size and kind
	// ****************************************
	localparam int MEM_OP_W = 8;

	localparam int MEM_LDB  = 0;
	localparam int MEM_LDH  = 1;
	localparam int MEM_LDW  = 2;
	localparam int MEM_STB  = 3;
	localparam int MEM_STH  = 4;
	localparam int MEM_STW  = 5;
	localparam int MEM_LDHU = 6;
	localparam int MEM_LLW  = 7;

	// Multiply codes.
	localparam int MUL_OP_W = 3;

	localparam logic [MUL_OP_W-1:0] MUL_LO  = 3'b001; // Low product word.
	localparam logic [MUL_OP_W-1:0] MUL_HI  = 3'b010; // Signed high word.
	localparam logic [MUL_OP_W-1:0] MUL_HIU = 3'b100; // Unsigned high word.

	localparam int ECODE_W = 6;
	localparam logic [ECODE_W-1:0] ECODE_ALE = 6'h09;

endpackage

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import ex_pkg::*; (
	input  logic [ALU_OP_W-1:0] alu_op,
	input  logic [31:0]         src1,
	input  logic [31:0]         src2,
	output logic [31:0]         result
);

	logic [31:0] add_res;
	logic [31:0] sub_res;
	logic [31:0] slt_res;
	logic [31:0] sltu_res;
	logic [31:0] and_res;
	logic [31:0] nor_res;
	logic [31:0] or_res;
	logic [31:0] xor_res;
	logic [31:0] sll_res;
	logic [31:0] srl_res;
	logic [31:0] sra_res;
	logic [31:0] lui_res;
	logic [4:0]  sa;

	assign sa = src2[4:0]; // Shift amount.

	assign add_res  = src1 + src2;
	assign sub_res  = src1 - src2;
	assign slt_res  = {31'b0, $signed(src1) < $signed(src2)};
	assign sltu_res = {31'b0, src1 < src2};
	assign and_res  = src1 & src2;
	assign nor_res  = ~(src1 | src2);
	assign or_res   = src1 | src2;
	assign xor_res  = src1 ^ src2;
	assign sll_res  = src1 << sa;
	assign srl_res  = src1 >> sa;
	assign sra_res  = $unsigned($signed(src1) >>> sa);
	assign lui_res  = src2; // Immediate comes in already shifted.

	// Only one select bit is set, so the masked terms simply OR together.
	assign result = ({32{alu_op[ALU_ADD]}}  & add_res)
	              | ({32{alu_op[ALU_SUB]}}  & sub_res)
	              | ({32{alu_op[ALU_SLT]}}  & slt_res)
	              | ({32{alu_op[ALU_SLTU]}} & sltu_res)
	              | ({32{alu_op[ALU_AND]}}  & and_res)
	              | ({32{alu_op[ALU_NOR]}}  & nor_res)
	              | ({32{alu_op[ALU_OR]}}   & or_res)
	              | ({32{alu_op[ALU_XOR]}}  & xor_res)
	              | ({32{alu_op[ALU_SLL]}}  & sll_res)
	              | ({32{alu_op[ALU_SRL]}}  & srl_res)
	              | ({32{alu_op[ALU_SRA]}}  & sra_res)
	              | ({32{alu_op[ALU_LUI]}}  & lui_res);

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
	input  logic                clk,
	input  logic                rst,

	input  logic                in_valid,
	output logic                in_ready,
	output logic                out_valid,
	input  logic                out_ready,

	input  logic [31:0]         pc,
	input  logic [ALU_OP_W-1:0] alu_op,
	input  logic                src1_is_pc,
	input  logic                src2_is_imm,
	input  logic [31:0]         imm,
	input  logic [31:0]         rj_value,
	input  logic [31:0]         rkd_value,
	input  logic [MEM_OP_W-1:0] mem_op,
	input  logic                res_from_mul,
	input  logic [MUL_OP_W-1:0] mul_op_in,
	input  logic                gr_we,
	input  logic [4:0]          dest,
	input  logic                has_exception,
	input  logic [ECODE_W-1:0]  ecode,
	input  logic                ertn,

	output logic                mul_req_valid,
	input  logic                mul_req_ready,
	output logic [31:0]         mul_src1,
	output logic [31:0]         mul_src2,
	output logic [MUL_OP_W-1:0] mul_op,

	output logic [31:0]         pc_out,
	output logic [31:0]         alu_result_out,
	output logic                res_from_mul_out,
	output logic                gr_we_out,
	output logic [4:0]          dest_out,
	output logic                has_exception_out,
	output logic [ECODE_W-1:0]  ecode_out,
	output logic [31:0]         badv_out,
	output logic                ertn_out
);

	logic        alive;
	logic        discard;
	logic        req_sent;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] alu_result;
	logic        half_acc;
	logic        word_acc;
	logic        ale;
	logic        exc;
	logic        kill;
	logic        need_mul;
	logic        mul_fire;
	logic        ready_go;
	logic        leave;

	assign src1 = src1_is_pc  ? pc  : rj_value;
	assign src2 = src2_is_imm ? imm : rkd_value;

	alu u_alu (
		.alu_op (alu_op),
		.src1   (src1),
		.src2   (src2),
		.result (alu_result)
	);

	assign half_acc = mem_op[MEM_LDH] | mem_op[MEM_STH] | mem_op[MEM_LDHU];
	assign word_acc = mem_op[MEM_LDW] | mem_op[MEM_STW] | mem_op[MEM_LLW];
	assign ale = half_acc & alu_result[0] | word_acc & (alu_result[1:0] != 2'b00);
	assign exc = has_exception | ale;

	assign kill     = discard & ~ertn; // Leaves as a bubble.
	assign need_mul = res_from_mul & ~exc & ~kill;

	// ****************************************
	// Multiply request and handshake
	// ****************************************
	assign mul_req_valid = in_valid & alive & need_mul & ~req_sent;
	assign mul_src1      = src1;
	assign mul_src2      = src2;
	assign mul_op        = mul_op_in;
	assign mul_fire      = mul_req_valid & mul_req_ready;

	assign ready_go = ~need_mul | req_sent | mul_fire;
	assign in_ready = alive & (~in_valid | ready_go & out_ready);
	assign leave    = in_valid & in_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			alive    <= 1'b0;
			discard  <= 1'b0;
			req_sent <= 1'b0;
		end else begin
			alive <= 1'b1;
			if (leave) begin
				if (ertn)
					discard <= 1'b0;
				else if (exc)
					discard <= 1'b1;
			end
			// Request already fired while the stage is held downstream.
			if (leave)
				req_sent <= 1'b0;
			else if (mul_fire)
				req_sent <= 1'b1;
		end
	end

	// ****************************************
	// Pipeline register
	// ****************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			pc_out    <= RESET_PC;
		end else begin
			if (out_ready)
				out_valid <= leave & ~kill;
			if (leave)
				pc_out <= pc;
		end
	end

	always_ff @(posedge clk) begin
		if (leave) begin
			alu_result_out    <= alu_result;
			res_from_mul_out  <= need_mul;
			gr_we_out         <= gr_we;
			dest_out          <= dest;
			has_exception_out <= exc;
			ecode_out         <= has_exception ? ecode : (ale ? ECODE_ALE : '0);
			badv_out          <= alu_result; // Faulting address.
			ertn_out          <= ertn;
		end
	end

endmodule

// ==== verilog/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit import ex_pkg::*; (
	input  logic                clk,
	input  logic                rst,

	input  logic                mul_req_valid,
	output logic                mul_req_ready,
	input  logic [31:0]         mul_src1,
	input  logic [31:0]         mul_src2,
	input  logic [MUL_OP_W-1:0] mul_op,

	output logic                mul_resp_valid,
	input  logic                mul_resp_ready,
	output logic [31:0]         mul_result
);

	logic                s1_valid;
	logic [63:0]         s1_prod;
	logic [MUL_OP_W-1:0] s1_op;
	logic                slot_valid;
	logic [31:0]         slot_data;
	logic                slot_free;
	logic                s1_free;
	logic                req_fire;
	logic                sgn;
	logic [65:0]         prod_full;

	assign sgn = (mul_op != MUL_HIU);
	// 33-bit operands cover both signed and unsigned products.
	assign prod_full = $signed({sgn & mul_src1[31], mul_src1}) *
	                   $signed({sgn & mul_src2[31], mul_src2});

	assign slot_free     = ~slot_valid | mul_resp_ready;
	assign s1_free       = ~s1_valid | slot_free;
	assign mul_req_ready = s1_free;
	assign req_fire      = mul_req_valid & mul_req_ready;

	assign mul_resp_valid = slot_valid;
	assign mul_result     = slot_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid   <= 1'b0;
			slot_valid <= 1'b0;
		end else begin
			if (s1_free)
				s1_valid <= mul_req_valid;
			if (slot_free)
				slot_valid <= s1_valid; // Result held until taken.
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			s1_prod <= prod_full[63:0];
			s1_op   <= mul_op;
		end
		if (slot_free & s1_valid)
			slot_data <= (s1_op == MUL_LO) ? s1_prod[31:0] : s1_prod[63:32];
	end

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage import ex_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
	input  logic               clk,
	input  logic               rst,

	input  logic               in_valid,
	output logic               in_ready,
	input  logic [31:0]        pc,
	input  logic [31:0]        alu_result,
	input  logic               res_from_mul,
	input  logic               gr_we,
	input  logic [4:0]         dest,
	input  logic               has_exception,
	input  logic [ECODE_W-1:0] ecode,
	input  logic [31:0]        badv,
	input  logic               ertn,

	input  logic               mul_resp_valid,
	output logic               mul_resp_ready,
	input  logic [31:0]        mul_result,

	output logic               wb_valid,
	input  logic               wb_ready,
	output logic [31:0]        wb_pc,
	output logic               wb_we,
	output logic [4:0]         wb_dest,
	output logic [31:0]        wb_data,
	output logic               wb_exc,
	output logic [ECODE_W-1:0] wb_ecode,
	output logic [31:0]        wb_badv,
	output logic               wb_ertn
);

	logic        valid;
	logic        mul_r;
	logic        mul_done;
	logic [31:0] data_r;
	logic        we_r;
	logic        ready_go;
	logic        fire_in;
	logic        resp_fire;

	// Multiply result can retire in the same cycle it arrives.
	assign ready_go  = ~mul_r | mul_done | mul_resp_valid;
	assign wb_valid  = valid & ready_go;
	assign in_ready  = ~valid | wb_valid & wb_ready;
	assign fire_in   = in_valid & in_ready;

	assign mul_resp_ready = valid & mul_r & ~mul_done;
	assign resp_fire      = mul_resp_valid & mul_resp_ready;

	assign wb_data = (mul_r & ~mul_done) ? mul_result : data_r;
	assign wb_we   = we_r & ~wb_exc; // No write for a faulting instruction.

	always_ff @(posedge clk) begin
		if (rst) begin
			valid    <= 1'b0;
			mul_done <= 1'b0;
			wb_pc    <= RESET_PC;
		end else begin
			if (in_ready)
				valid <= in_valid;
			if (fire_in) begin
				wb_pc    <= pc;
				mul_done <= 1'b0;
			end else if (resp_fire) begin
				mul_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire_in) begin
			data_r   <= alu_result;
			mul_r    <= res_from_mul;
			we_r     <= gr_we;
			wb_dest  <= dest;
			wb_exc   <= has_exception;
			wb_ecode <= ecode;
			wb_badv  <= badv;
			wb_ertn  <= ertn;
		end else if (resp_fire) begin
			data_r <= mul_result; // Merge the product.
		end
	end

endmodule

// ==== verilog/ex_pipe_top.sv ====
`timescale 1ns/1ps

module ex_pipe_top import ex_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
	input  logic                clk,
	input  logic                rst,

	input  logic                in_valid,
	output logic                in_ready,
	input  logic [31:0]         pc,
	input  logic [ALU_OP_W-1:0] alu_op,
	input  logic                src1_is_pc,
	input  logic                src2_is_imm,
	input  logic [31:0]         imm,
	input  logic [31:0]         rj_value,
	input  logic [31:0]         rkd_value,
	input  logic [MEM_OP_W-1:0] mem_op,
	input  logic                res_from_mul,
	input  logic [MUL_OP_W-1:0] mul_op,
	input  logic                gr_we,
	input  logic [4:0]          dest,
	input  logic                has_exception,
	input  logic [ECODE_W-1:0]  ecode,
	input  logic                ertn,

	output logic                wb_valid,
	input  logic                wb_ready,
	output logic [31:0]         wb_pc,
	output logic                wb_we,
	output logic [4:0]          wb_dest,
	output logic [31:0]         wb_data,
	output logic                wb_exc,
	output logic [ECODE_W-1:0]  wb_ecode,
	output logic [31:0]         wb_badv,
	output logic                wb_ertn
);

	logic                ex_valid;
	logic                mem_ready;
	logic [31:0]         ex_pc;
	logic [31:0]         ex_alu_result;
	logic                ex_res_from_mul;
	logic                ex_gr_we;
	logic [4:0]          ex_dest;
	logic                ex_exc;
	logic [ECODE_W-1:0]  ex_ecode;
	logic [31:0]         ex_badv;
	logic                ex_ertn;

	logic                mul_req_valid;
	logic                mul_req_ready;
	logic [31:0]         mul_src1;
	logic [31:0]         mul_src2;
	logic [MUL_OP_W-1:0] ex_mul_op;
	logic                mul_resp_valid;
	logic                mul_resp_ready;
	logic [31:0]         mul_result;

	ex_stage #(
		.RESET_PC (RESET_PC)
	) u_ex_stage (
		.clk               (clk),
		.rst               (rst),
		.in_valid          (in_valid),
		.in_ready          (in_ready),
		.out_valid         (ex_valid),
		.out_ready         (mem_ready),
		.pc                (pc),
		.alu_op            (alu_op),
		.src1_is_pc        (src1_is_pc),
		.src2_is_imm       (src2_is_imm),
		.imm               (imm),
		.rj_value          (rj_value),
		.rkd_value         (rkd_value),
		.mem_op            (mem_op),
		.res_from_mul      (res_from_mul),
		.mul_op_in         (mul_op),
		.gr_we             (gr_we),
		.dest              (dest),
		.has_exception     (has_exception),
		.ecode             (ecode),
		.ertn              (ertn),
		.mul_req_valid     (mul_req_valid),
		.mul_req_ready     (mul_req_ready),
		.mul_src1          (mul_src1),
		.mul_src2          (mul_src2),
		.mul_op            (ex_mul_op),
		.pc_out            (ex_pc),
		.alu_result_out    (ex_alu_result),
		.res_from_mul_out  (ex_res_from_mul),
		.gr_we_out         (ex_gr_we),
		.dest_out          (ex_dest),
		.has_exception_out (ex_exc),
		.ecode_out         (ex_ecode),
		.badv_out          (ex_badv),
		.ertn_out          (ex_ertn)
	);

	mul_unit u_mul_unit (
		.clk            (clk),
		.rst            (rst),
		.mul_req_valid  (mul_req_valid),
		.mul_req_ready  (mul_req_ready),
		.mul_src1       (mul_src1),
		.mul_src2       (mul_src2),
		.mul_op         (ex_mul_op),
		.mul_resp_valid (mul_resp_valid),
		.mul_resp_ready (mul_resp_ready),
		.mul_result     (mul_result)
	);

	mem_stage #(
		.RESET_PC (RESET_PC)
	) u_mem_stage (
		.clk            (clk),
		.rst            (rst),
		.in_valid       (ex_valid),
		.in_ready       (mem_ready),
		.pc             (ex_pc),
		.alu_result     (ex_alu_result),
		.res_from_mul   (ex_res_from_mul),
		.gr_we          (ex_gr_we),
		.dest           (ex_dest),
		.has_exception  (ex_exc),
		.ecode          (ex_ecode),
		.badv           (ex_badv),
		.ertn           (ex_ertn),
		.mul_resp_valid (mul_resp_valid),
		.mul_resp_ready (mul_resp_ready),
		.mul_result     (mul_result),
		.wb_valid       (wb_valid),
		.wb_ready       (wb_ready),
		.wb_pc          (wb_pc),
		.wb_we          (wb_we),
		.wb_dest        (wb_dest),
		.wb_data        (wb_data),
		.wb_exc         (wb_exc),
		.wb_ecode       (wb_ecode),
		.wb_badv        (wb_badv),
		.wb_ertn        (wb_ertn)
	);

endmodule

// ==== verification/ex_pipe_model.svh ====
`ifndef EX_PIPE_MODEL_SVH
`define EX_PIPE_MODEL_SVH

// ****************************************
// Reference results for the retire port
// ****************************************

// Op is the index of the set bit in the one-hot ALU operation.
function automatic logic [31:0] alu_model(input int op, input logic [31:0] a,
		input logic [31:0] b);
	logic [31:0] r;
	case (op)
		ALU_ADD:  r = a + b;
		ALU_SUB:  r = a - b;
		ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
		ALU_AND:  r = a & b;
		ALU_NOR:  r = ~(a | b);
		ALU_OR:   r = a | b;
		ALU_XOR:  r = a ^ b;
		ALU_SLL:  r = a << b[4:0];
		ALU_SRL:  r = a >> b[4:0];
		ALU_SRA:  r = $signed(a) >>> b[4:0];
		ALU_LUI:  r = b;
		default:  r = '0;
	endcase
	return r;
endfunction

function automatic logic [31:0] mul_model(input logic [MUL_OP_W-1:0] op,
		input logic [31:0] a, input logic [31:0] b);
	logic signed [63:0] sp;
	logic [63:0]        up;
	logic [31:0]        r;
	sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
	up = {32'b0, a} * {32'b0, b};
	if (op == MUL_HI)
		r = sp[63:32];
	else if (op == MUL_HIU)
		r = up[63:32];
	else
		r = up[31:0]; // Low word is the same for both signs.
	return r;
endfunction

// Halfwords need an even address, words a multiple of four.
function automatic logic misaligned(input logic [MEM_OP_W-1:0] kind, input logic [31:0] addr);
	logic half;
	logic word;
	half = kind[MEM_LDH] | kind[MEM_STH] | kind[MEM_LDHU];
	word = kind[MEM_LDW] | kind[MEM_STW] | kind[MEM_LLW];
	return (half && addr[0]) || (word && addr[1:0] != 2'b00);
endfunction

`endif

// ==== verification/ex_pipe_tb.sv ====
`timescale 1ns/1ps

module ex_pipe_tb import ex_pkg::*; ();

	localparam logic [31:0] RESET_PC   = 32'h1c00_0000;
	localparam int          N_INSTR    = 2000;
	localparam int          WAIT_LIMIT = 200;

	typedef struct packed {
		logic [31:0]        pc;
		logic               we;
		logic [4:0]         dest;
		logic [31:0]        data;
		logic               exc;
		logic [ECODE_W-1:0] ecode;
		logic [31:0]        badv;
		logic               ertn;
	} retire_t;

	logic                clk = 1'b0;
	logic                rst;
	logic                in_valid;
	logic                in_ready;
	logic [31:0]         pc;
	logic [ALU_OP_W-1:0] alu_op;
	logic                src1_is_pc;
	logic                src2_is_imm;
	logic [31:0]         imm;
	logic [31:0]         rj_value;
	logic [31:0]         rkd_value;
	logic [MEM_OP_W-1:0] mem_op;
	logic                res_from_mul;
	logic [MUL_OP_W-1:0] mul_op;
	logic                gr_we;
	logic [4:0]          dest;
	logic                has_exception;
	logic [ECODE_W-1:0]  ecode;
	logic                ertn;
	logic                wb_valid;
	logic                wb_ready = 1'b0;
	logic [31:0]         wb_pc;
	logic                wb_we;
	logic [4:0]          wb_dest;
	logic [31:0]         wb_data;
	logic                wb_exc;
	logic [ECODE_W-1:0]  wb_ecode;
	logic [31:0]         wb_badv;
	logic                wb_ertn;

	retire_t     exp_q[$];
	logic        discard; // Model of the sticky discard state.
	logic [31:0] next_pc;
	int          cur_alu_idx;
	int          errors;
	int          timeouts;
	int          checks;
	int          retired;
	int          discarded;
	int          exc_seen;
	int          ertn_seen;

	`include "ex_pipe_model.svh"

	ex_pipe_top #(
		.RESET_PC (RESET_PC)
	) dut0 (.*);

	always #4 clk = ~clk;

	// Random back-pressure at the retire port.
	always @(posedge clk) begin
		#1;
		wb_ready = ($urandom % 4) != 0;
	end

	always @(negedge clk) begin
		if (!rst && wb_valid && wb_ready)
			check_retire();
	end

	// ****************************************
	// Stimulus
	// ****************************************
	task automatic init_inputs;
		in_valid      = 1'b0;
		pc            = RESET_PC;
		alu_op        = '0;
		src1_is_pc    = 1'b0;
		src2_is_imm   = 1'b0;
		imm           = '0;
		rj_value      = '0;
		rkd_value     = '0;
		mem_op        = '0;
		res_from_mul  = 1'b0;
		mul_op        = MUL_LO;
		gr_we         = 1'b0;
		dest          = '0;
		has_exception = 1'b0;
		ecode         = '0;
		ertn          = 1'b0;
	endtask

	task automatic drive_random;
		int kind;
		kind = $urandom % 4; // 0 and 1 ALU, 2 multiply, 3 memory.
		cur_alu_idx   = $urandom % ALU_OP_W;
		pc            = next_pc;
		src1_is_pc    = ($urandom % 4) == 0;
		src2_is_imm   = ($urandom % 2) == 0;
		imm           = $urandom;
		rj_value      = $urandom;
		rkd_value     = $urandom;
		mem_op        = '0;
		res_from_mul  = 1'b0;
		mul_op        = MUL_LO;
		gr_we         = ($urandom % 8) != 0;
		dest          = 5'($urandom);
		has_exception = ($urandom % 16) == 0;
		ecode         = ECODE_W'($urandom);
		ertn          = ($urandom % 8) == 0;
		if (kind == 2) begin
			res_from_mul = 1'b1;
			case ($urandom % 3)
				0:       mul_op = MUL_LO;
				1:       mul_op = MUL_HI;
				default: mul_op = MUL_HIU;
			endcase
		end else if (kind == 3) begin
			cur_alu_idx = ALU_ADD; // Address add.
			mem_op = MEM_OP_W'(1) << ($urandom % MEM_OP_W);
			if ($urandom % 2 == 0) begin
				rj_value[1:0]  = 2'b00;
				rkd_value[1:0] = 2'b00;
				imm[1:0]       = 2'b00;
			end
		end
		alu_op = ALU_OP_W'(1) << cur_alu_idx;
		in_valid = 1'b1;
	endtask

	// Called at acceptance. Discarded instructions expect nothing.
	task automatic record_accept;
		retire_t     r;
		logic [31:0] s1;
		logic [31:0] s2;
		logic [31:0] res;
		logic        ale;
		logic        exc;
		s1  = src1_is_pc ? pc : rj_value;
		s2  = src2_is_imm ? imm : rkd_value;
		res = alu_model(cur_alu_idx, s1, s2);
		ale = misaligned(mem_op, res);
		exc = has_exception | ale;
		if (discard && !ertn) begin
			discarded++;
		end else begin
			r.pc    = pc;
			r.we    = gr_we & ~exc;
			r.dest  = dest;
			r.data  = (res_from_mul && !exc) ? mul_model(mul_op, s1, s2) : res;
			r.exc   = exc;
			r.ecode = has_exception ? ecode : ECODE_ALE;
			r.badv  = res;
			r.ertn  = ertn;
			exp_q.push_back(r);
		end
		if (ertn)
			discard = 1'b0;
		else if (exc)
			discard = 1'b1;
	endtask

	task automatic send_one(output logic late);
		int waited;
		late   = 1'b0;
		waited = 0;
		drive_random();
		@(negedge clk);
		while (!in_ready && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		assert (in_ready) else begin
			$display("Timeout: instruction at pc %h was never accepted", pc);
			late = 1'b1;
		end
		if (!late)
			record_accept();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		next_pc  = next_pc + 32'd4;
	endtask

	task automatic drain(output logic late);
		int waited;
		late   = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && waited < 4 * WAIT_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			$display("Timeout: %0d instructions never retired", exp_q.size());
			late = 1'b1;
		end
		repeat (20) @(posedge clk); // Room for a stray retire to show up.
	endtask

	// ****************************************
	// Checking
	// ****************************************
	task automatic compare_word(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("FAILED %s: expected %h, got %h (pc %h)", name, want, got, wb_pc);
		end
	endtask

	task automatic check_retire;
		retire_t e;
		retired++;
		assert (exp_q.size() != 0) else begin
			errors++;
			$display("Instruction at pc %h retired while none was outstanding", wb_pc);
		end
		if (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			compare_word("wb_pc", wb_pc, e.pc);
			compare_word("wb_dest", 32'(wb_dest), 32'(e.dest));
			compare_word("wb_we", 32'(wb_we), 32'(e.we));
			compare_word("wb_exc", 32'(wb_exc), 32'(e.exc));
			compare_word("wb_ertn", 32'(wb_ertn), 32'(e.ertn));
			if (e.exc) begin
				compare_word("wb_ecode", 32'(wb_ecode), 32'(e.ecode));
				compare_word("wb_badv", wb_badv, e.badv);
				exc_seen++;
			end else begin
				compare_word("wb_data", wb_data, e.data);
			end
			if (e.ertn)
				ertn_seen++;
		end
	endtask

	task automatic finish_run;
		$display("Retired %0d, discarded %0d, exc %0d, ertn %0d, checks %0d, errors %0d, timeouts %0d",
			retired, discarded, exc_seen, ertn_seen, checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	initial begin
		logic late;
		int   gap;
		void'($urandom(32'h98fb));
		init_inputs();
		discard = 1'b0;
		next_pc = RESET_PC;
		late    = 1'b0;
		rst     = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int i = 0; i < N_INSTR && !late; i++) begin
			send_one(late);
			gap = (($urandom % 4) == 0) ? int'($urandom % 3) + 1 : 0;
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
		end
		if (!late)
			drain(late);
		if (late)
			timeouts++;
		finish_run();
	end

endmodule

// ==== vlog.f ====
+incdir+verification
verilog/ex_pkg.sv
verilog/alu.sv
verilog/ex_stage.sv
verilog/mul_unit.sv
verilog/mem_stage.sv
verilog/ex_pipe_top.sv
verification/ex_pipe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= ex_pipe_tb
RTL_TOP   ?= ex_pipe_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR) -o V$(TB_TOP)
	$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "All tests passed!" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
